// File: fetch_pkg.sv
package fetch_pkg;

    localparam int ADDR_WIDTH      = 32;
    localparam int WORD_WIDTH      = 32;
    localparam int TRAP_CODE_WIDTH = 4;
    localparam int OPCODE_WIDTH    = 7;

    typedef logic [ADDR_WIDTH-1:0]      addr_t;
    typedef logic [WORD_WIDTH-1:0]      word_t;
    typedef logic [TRAP_CODE_WIDTH-1:0] trap_code_t;
    typedef logic [OPCODE_WIDTH-1:0]    opcode_t;
    typedef logic [1:0]                 mode_t;
    typedef logic [1:0]                 axi_resp_t;

    // privilege modes, 2 is reserved
    localparam mode_t MODE_USER    = 2'd0;
    localparam mode_t MODE_SUPER   = 2'd1;
    localparam mode_t MODE_MACHINE = 2'd3;

    // mcause codes
    localparam trap_code_t TRAP_MISALIGNED   = 4'd0;
    localparam trap_code_t TRAP_ACCESS_FAULT = 4'd1;
    localparam trap_code_t TRAP_SW_INT       = 4'd3;
    localparam trap_code_t TRAP_TIMER_INT    = 4'd7;
    localparam trap_code_t TRAP_EXT_INT      = 4'd11;

    // opcodes that hold fetch until retired
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_SYSTEM = 7'b1110011;

    localparam axi_resp_t RESP_OKAY = 2'b00;

    localparam addr_t PC_INIT_DEFAULT = 32'h8000_0000;

endpackage

// File: ibus_reader.sv
`timescale 1ns/1ps

module ibus_reader (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  req_valid,
    input  fetch_pkg::addr_t      req_addr,
    output logic                  req_ready,
    output logic                  rsp_valid,
    output fetch_pkg::word_t      rsp_data,
    output logic                  rsp_error,

    output logic                  arvalid,
    input  logic                  arready,
    output fetch_pkg::addr_t      araddr,
    output logic [2:0]            arprot,
    input  logic                  rvalid,
    output logic                  rready,
    input  fetch_pkg::word_t      rdata,
    input  fetch_pkg::axi_resp_t  rresp
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA
    } state_t;

    localparam logic [2:0] ARPROT_INST = 3'b100; // unprivileged, secure, instruction

    state_t state;

    assign req_ready = state == IDLE;
    assign arvalid   = state == ADDR;
    assign rready    = state == DATA;
    assign arprot    = ARPROT_INST;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                IDLE: if (req_valid) state <= ADDR;
                ADDR: if (arready) state <= DATA;
                DATA: begin
                    if (rvalid) begin
                        state     <= IDLE;
                        rsp_valid <= 1'b1; // single pulse back to the sequencer
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) araddr <= req_addr; // held through AR
        if (rvalid && rready) begin
            rsp_data  <= rdata;
            rsp_error <= rresp != fetch_pkg::RESP_OKAY;
        end
    end

endmodule

// File: trap_detector.sv
`timescale 1ns/1ps

module trap_detector (
    input  logic                   clk,
    input  logic                   rst,

    input  fetch_pkg::addr_t       next_pc,
    input  logic                   trint,
    input  logic                   swint,
    input  logic                   exint,
    input  fetch_pkg::mode_t       priv_mode,
    input  logic                   mie,

    output logic                   trap_pending,
    output fetch_pkg::trap_code_t  trap_code,
    output logic                   trap_is_exception
);

    logic int_en;
    logic misaligned;

    always_comb begin
        case (priv_mode)
            fetch_pkg::MODE_USER,
            fetch_pkg::MODE_SUPER:   int_en = 1'b1; // always taken below machine mode
            fetch_pkg::MODE_MACHINE: int_en = mie;
            default:                 int_en = 1'b0;
        endcase
    end

    assign misaligned = next_pc[1:0] != 2'b00;

    // registered so the sequencer sees one decision per cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            trap_pending      <= 1'b0;
            trap_code         <= fetch_pkg::TRAP_MISALIGNED;
            trap_is_exception <= 1'b0;
        end else begin
            trap_pending      <= 1'b1;
            trap_is_exception <= 1'b0;
            if (int_en && swint) begin
                trap_code <= fetch_pkg::TRAP_SW_INT;
            end else if (int_en && trint) begin
                trap_code <= fetch_pkg::TRAP_TIMER_INT;
            end else if (int_en && exint) begin
                trap_code <= fetch_pkg::TRAP_EXT_INT;
            end else if (misaligned) begin
                trap_code         <= fetch_pkg::TRAP_MISALIGNED;
                trap_is_exception <= 1'b1;
            end else begin
                trap_pending <= 1'b0;
                trap_code    <= fetch_pkg::TRAP_MISALIGNED;
            end
        end
    end

endmodule

// File: fetch_sequencer.sv
`timescale 1ns/1ps

module fetch_sequencer #(
    parameter fetch_pkg::addr_t pc_init = fetch_pkg::PC_INIT_DEFAULT
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   enable,
    input  logic                   jump_valid,
    input  fetch_pkg::addr_t       jump_dest,
    input  fetch_pkg::word_t       retire_count,

    input  logic                   trap_pending,
    input  fetch_pkg::trap_code_t  trap_code,
    input  logic                   trap_is_exception,
    output fetch_pkg::addr_t       next_pc,

    output logic                   req_valid,
    output fetch_pkg::addr_t       req_addr,
    input  logic                   req_ready,
    input  logic                   rsp_valid,
    input  fetch_pkg::word_t       rsp_data,
    input  logic                   rsp_error,

    output fetch_pkg::addr_t       pc,
    output logic                   ok,
    output logic                   fetch_valid,
    output fetch_pkg::word_t       fetch_inst,
    output fetch_pkg::addr_t       fetch_pc,
    output fetch_pkg::word_t       fetch_count,
    output logic                   fetch_trap,
    output fetch_pkg::trap_code_t  fetch_trap_code,
    output logic                   fetch_is_exception
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_BUS,
        STALL
    } state_t;

    state_t              state;
    fetch_pkg::word_t    count;   // counter of the last emitted instruction
    fetch_pkg::addr_t    cand_q;  // next_pc as the detector saw it
    fetch_pkg::opcode_t  rsp_op;
    logic                settled;
    logic                take_trap;
    logic                launch;
    logic                stall_op;

    assign next_pc = jump_valid ? jump_dest : pc + fetch_pkg::addr_t'(4);

    // detector output lags next_pc by one cycle, so only act once they agree
    assign settled   = cand_q == next_pc;
    assign ok        = (state == IDLE) && settled;
    assign take_trap = ok && enable && trap_pending;
    assign launch    = ok && enable && !trap_pending;

    assign rsp_op   = rsp_data[6:0];
    assign stall_op = rsp_op inside {fetch_pkg::OP_BRANCH, fetch_pkg::OP_JAL,
                                     fetch_pkg::OP_JALR, fetch_pkg::OP_LOAD,
                                     fetch_pkg::OP_STORE, fetch_pkg::OP_SYSTEM};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            pc          <= pc_init - fetch_pkg::addr_t'(4); // first fetch lands on pc_init
            cand_q      <= pc_init;
            count       <= '0;
            req_valid   <= 1'b0;
            fetch_valid <= 1'b0;
            fetch_trap  <= 1'b0;
        end else begin
            cand_q      <= next_pc;
            fetch_valid <= 1'b0;
            fetch_trap  <= 1'b0;
            if (req_valid && req_ready) req_valid <= 1'b0;

            case (state)
                IDLE: begin
                    if (take_trap) begin
                        fetch_trap <= 1'b1; // nop bubble, pc stays put
                        count      <= count + fetch_pkg::word_t'(1);
                        state      <= STALL;
                    end else if (launch) begin
                        req_valid <= 1'b1;
                        pc        <= next_pc; // jump consumed here
                        state     <= WAIT_BUS;
                    end
                end
                WAIT_BUS: begin
                    if (rsp_valid) begin
                        count <= count + fetch_pkg::word_t'(1);
                        if (rsp_error) begin
                            fetch_trap <= 1'b1;
                            state      <= STALL;
                        end else begin
                            fetch_valid <= 1'b1;
                            state       <= stall_op ? STALL : IDLE;
                        end
                    end
                end
                STALL: if (retire_count == count) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // decode payload, only meaningful with fetch_valid or fetch_trap
    always_ff @(posedge clk) begin
        if (launch) req_addr <= next_pc;

        if (take_trap) begin
            fetch_inst         <= '0;
            fetch_pc           <= next_pc;
            fetch_count        <= count + fetch_pkg::word_t'(1);
            fetch_trap_code    <= trap_code;
            fetch_is_exception <= trap_is_exception;
        end else if (state == WAIT_BUS && rsp_valid) begin
            fetch_inst         <= rsp_error ? '0 : rsp_data;
            fetch_pc           <= pc;
            fetch_count        <= count + fetch_pkg::word_t'(1);
            fetch_trap_code    <= fetch_pkg::TRAP_ACCESS_FAULT;
            fetch_is_exception <= rsp_error;
        end
    end

endmodule

// File: fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter fetch_pkg::addr_t pc_init = fetch_pkg::PC_INIT_DEFAULT
) (
    input  logic                   clk,
    input  logic                   rst,

    // instruction bus, read channels only
    output logic                   arvalid,
    input  logic                   arready,
    output fetch_pkg::addr_t       araddr,
    output logic [2:0]             arprot,
    input  logic                   rvalid,
    output logic                   rready,
    input  fetch_pkg::word_t       rdata,
    input  fetch_pkg::axi_resp_t   rresp,

    // back end
    input  logic                   enable,
    input  logic                   jump_valid,
    input  fetch_pkg::addr_t       jump_dest,
    input  fetch_pkg::word_t       retire_count,
    input  logic                   trint,
    input  logic                   swint,
    input  logic                   exint,
    input  fetch_pkg::mode_t       priv_mode,
    input  logic                   mie,

    output logic                   fetch_valid,
    output fetch_pkg::word_t       fetch_inst,
    output fetch_pkg::addr_t       fetch_pc,
    output fetch_pkg::word_t       fetch_count,
    output logic                   fetch_trap,
    output fetch_pkg::trap_code_t  fetch_trap_code,
    output logic                   fetch_is_exception,
    output fetch_pkg::addr_t       pc,
    output logic                   ok
);

    // sequencer <-> reader
    logic                   req_valid;
    logic                   req_ready;
    fetch_pkg::addr_t       req_addr;
    logic                   rsp_valid;
    fetch_pkg::word_t       rsp_data;
    logic                   rsp_error;

    // sequencer <-> detector
    fetch_pkg::addr_t       next_pc;
    logic                   trap_pending;
    fetch_pkg::trap_code_t  trap_code;
    logic                   trap_is_exception;

    ibus_reader i_ibus_reader (.*);

    trap_detector i_trap_detector (.*);

    fetch_sequencer #(
        .pc_init(pc_init)
    ) i_fetch_sequencer (.*);

endmodule

// File: tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;

    localparam fetch_pkg::addr_t     PC_START    = 32'h0000_1000;
    localparam fetch_pkg::addr_t     BRANCH_ADDR = 32'h0000_1010;
    localparam fetch_pkg::addr_t     JUMP_ADDR   = 32'h0000_2000;
    localparam fetch_pkg::addr_t     FAULT_ADDR  = 32'h0000_2010; // answers with SLVERR
    localparam fetch_pkg::addr_t     ODD_ADDR    = 32'h0000_3002;
    localparam fetch_pkg::opcode_t   OP_IMM      = 7'b0010011;
    localparam fetch_pkg::axi_resp_t RESP_SLVERR = 2'b10;
    localparam int RETIRE_DELAY = 3;
    localparam int RESET_CYCLES = 3;
    // pulses waited for by each test in run order
    localparam int TEST_STEPS = 8 + 4 + 3 + 3 + 5 + 3;

    logic clk = 1'b0;
    logic rst;

    logic arvalid, rready, fetch_valid, fetch_trap, fetch_is_exception, ok;
    fetch_pkg::addr_t araddr, fetch_pc, pc;
    logic [2:0] arprot;
    fetch_pkg::word_t fetch_inst, fetch_count;
    fetch_pkg::trap_code_t fetch_trap_code;

    logic arready = 1'b0;
    logic rvalid = 1'b0;
    fetch_pkg::word_t rdata = '0;
    fetch_pkg::axi_resp_t rresp = fetch_pkg::RESP_OKAY;
    fetch_pkg::word_t retire_count = '0;
    logic enable, jump_valid, trint, swint, exint, mie;
    fetch_pkg::addr_t jump_dest;
    fetch_pkg::mode_t priv_mode;

    integer seed = 23149;
    string test_name = "reset";
    logic expect_no_trap;
    logic stall_open;
    logic r_pending;
    fetch_pkg::addr_t seq_pc, cand_pc, r_addr;
    fetch_pkg::word_t last_count, stall_count;
    int ar_delay, r_delay, retire_wait;

    fetch_top #(
        .pc_init(PC_START)
    ) i_fetch_top (.*);

    always #20 clk = ~clk;

    function automatic fetch_pkg::word_t mem_word(input fetch_pkg::addr_t a);
        fetch_pkg::word_t w;
        w = {a[11:0] ^ a[23:12], a[28:24], 3'b000, 2'b00, a[31:29], OP_IMM}; // addi
        if (a == BRANCH_ADDR) w[6:0] = fetch_pkg::OP_BRANCH;
        return w;
    endfunction

    function automatic logic holds_fetch(input fetch_pkg::opcode_t op);
        return op == fetch_pkg::OP_BRANCH || op == fetch_pkg::OP_JAL
            || op == fetch_pkg::OP_JALR || op == fetch_pkg::OP_LOAD
            || op == fetch_pkg::OP_STORE || op == fetch_pkg::OP_SYSTEM;
    endfunction

    // {exception, code} expected for a bubble at address a
    function automatic logic [4:0] predict_trap(input fetch_pkg::addr_t a);
        logic int_en;
        int_en = priv_mode != fetch_pkg::MODE_MACHINE || mie;
        if (int_en && swint) return {1'b0, fetch_pkg::TRAP_SW_INT};
        if (int_en && trint) return {1'b0, fetch_pkg::TRAP_TIMER_INT};
        if (int_en && exint) return {1'b0, fetch_pkg::TRAP_EXT_INT};
        if (a[1:0] != 2'b00) return {1'b1, fetch_pkg::TRAP_MISALIGNED};
        return {1'b1, fetch_pkg::TRAP_ACCESS_FAULT}; // only bus errors left
    endfunction

    task automatic mismatch(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
        $display("error %s, %s: expected %h, actual %h", test_name, what, expected, actual);
        $display("Errors found");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic violation(input string what);
        $display("%s during %s", what, test_name);
        $display("Errors found");
        $fatal(1, "stopped at the first failing check");
    endtask

    // memory model with 0 to 3 wait cycles on AR and on R
    always @(posedge clk) begin
        if (rst) begin
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            r_pending <= 1'b0;
            ar_delay  <= 0;
        end else begin
            arready <= 1'b0;
            if (arvalid && !arready) begin
                if (ar_delay == 0) begin
                    arready  <= 1'b1;
                    ar_delay <= $random(seed) & 3;
                end else begin
                    ar_delay <= ar_delay - 1;
                end
            end
            if (arvalid && arready) begin
                r_pending <= 1'b1;
                r_addr    <= araddr;
                r_delay   <= $random(seed) & 3;
            end
            if (rvalid && rready) rvalid <= 1'b0;
            if (r_pending) begin
                if (r_delay == 0) begin
                    rvalid    <= 1'b1;
                    rdata     <= mem_word(r_addr);
                    rresp     <= r_addr == FAULT_ADDR ? RESP_SLVERR : fetch_pkg::RESP_OKAY;
                    r_pending <= 1'b0;
                end else begin
                    r_delay <= r_delay - 1;
                end
            end
        end
    end

    // back end retires a stalling instruction a few cycles after it shows up
    always @(posedge clk) begin
        if (rst) begin
            retire_count <= '0;
            stall_open   <= 1'b0;
            stall_count  <= '0;
            retire_wait  <= 0;
        end else if ((fetch_valid && holds_fetch(fetch_inst[6:0])) || fetch_trap) begin
            stall_open  <= 1'b1;
            stall_count <= fetch_count;
            retire_wait <= RETIRE_DELAY;
        end else if (stall_open) begin
            if (retire_count == stall_count) stall_open <= 1'b0;
            else if (retire_wait == 0) retire_count <= stall_count;
            else retire_wait <= retire_wait - 1;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            seq_pc     <= PC_START;
            cand_pc    <= PC_START;
            last_count <= '0;
        end else begin
            if (ok && enable) cand_pc <= jump_valid ? jump_dest : seq_pc; // fetch or trap here
            if (arvalid && arready) begin
                assert (araddr[1:0] == 2'b00)
                    else violation("AR handshake on a misaligned address");
                assert (araddr == cand_pc) else mismatch("araddr", cand_pc, araddr);
                assert (arprot[2]) else mismatch("arprot instruction bit", 1, arprot[2]);
                seq_pc <= cand_pc + 32'd4;
            end
            assert (!rready || r_pending || rvalid)
                else violation("rready high with no read address accepted");
            assert (!(stall_open && arvalid))
                else violation("AR request while a retire stall was open");
            if (fetch_valid || fetch_trap) begin
                assert (fetch_pc == cand_pc) else mismatch("fetch_pc", cand_pc, fetch_pc);
                assert (fetch_count == last_count + 1)
                    else mismatch("fetch_count", last_count + 1, fetch_count);
                last_count <= fetch_count;
            end
            if (fetch_valid) begin
                assert (!fetch_trap) else violation("fetch_valid and fetch_trap high together");
                assert (cand_pc != FAULT_ADDR)
                    else violation("SLVERR response passed on as an instruction");
                assert (pc == cand_pc) else mismatch("pc", cand_pc, pc);
                assert (fetch_inst == mem_word(cand_pc))
                    else mismatch("fetch_inst", mem_word(cand_pc), fetch_inst);
            end
            if (fetch_trap) begin
                assert (!expect_no_trap) else violation("trap bubble with interrupts masked");
                assert (fetch_inst == '0) else mismatch("bubble inst", '0, fetch_inst);
                assert ({fetch_is_exception, fetch_trap_code} == predict_trap(cand_pc))
                    else mismatch("trap", predict_trap(cand_pc),
                                  {fetch_is_exception, fetch_trap_code});
            end
        end
    end

    task automatic count_fetches(input int n);
        repeat (n) begin
            @(posedge clk);
            while (!fetch_valid) @(posedge clk);
        end
    endtask

    task automatic await_bubble;
        @(posedge clk);
        while (!fetch_trap) @(posedge clk);
    endtask

    task automatic jump_to(input fetch_pkg::addr_t dest);
        jump_valid <= 1'b1;
        jump_dest  <= dest;
        @(posedge clk);
        while (!ok) @(posedge clk);
        jump_valid <= 1'b0; // sampled by the DUT at this edge
    endtask

    task automatic interrupt_bubble(input logic sw, input logic ti, input logic ex);
        swint <= sw;
        trint <= ti;
        exint <= ex;
        await_bubble();
        swint <= 1'b0;
        trint <= 1'b0;
        exint <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        rst            = 1'b1;
        enable         = 1'b0;
        jump_valid     = 1'b0;
        jump_dest      = '0;
        trint          = 1'b0;
        swint          = 1'b0;
        exint          = 1'b0;
        priv_mode      = fetch_pkg::MODE_USER;
        mie            = 1'b0;
        expect_no_trap = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst       <= 1'b0;
        enable    <= 1'b1;
        test_name = "sequential fetch";
        count_fetches(8); // branch at BRANCH_ADDR stalls on the way
        test_name = "jump redirect";
        jump_to(JUMP_ADDR);
        count_fetches(4);
        test_name = "bus error";
        await_bubble();
        count_fetches(2);
        test_name = "interrupt priority";
        interrupt_bubble(1'b1, 1'b1, 1'b1);
        interrupt_bubble(1'b0, 1'b1, 1'b1);
        interrupt_bubble(1'b0, 1'b0, 1'b1);
        test_name = "interrupt masking";
        priv_mode      <= fetch_pkg::MODE_MACHINE;
        swint          <= 1'b1;
        expect_no_trap <= 1'b1;
        count_fetches(4);
        mie            <= 1'b1;
        expect_no_trap <= 1'b0;
        await_bubble();
        swint     <= 1'b0;
        priv_mode <= fetch_pkg::MODE_USER;
        @(posedge clk);
        test_name = "misaligned target";
        jump_to(ODD_ADDR);
        await_bubble();
        count_fetches(2);
        $display("No errors");
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + TEST_STEPS * 20) @(posedge clk);
        $display("timeout: tests still running after %0d cycles", RESET_CYCLES + TEST_STEPS * 20);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: verilog.f
fetch_pkg.sv
ibus_reader.sv
trap_detector.sv
fetch_sequencer.sv
fetch_top.sv
tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch_stage

sources:
  - fetch_pkg.sv
  - ibus_reader.sv
  - trap_detector.sv
  - fetch_sequencer.sv
  - fetch_top.sv
  - target: test
    files:
      - tb_fetch_top.sv
